/* filelist.f */
+incdir+.
stream_pkg.sv
ctrl_pkg.sv
stream_fifo.sv
word_mem.sv
mem_arbiter.sv
apb_ctrl_regs.sv
stream_reader.sv
stream_writer.sv
stream_copy_top.sv
tb_stream_copy.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps --Wno-fatal -j 0
TOP      = tb_stream_copy
FILELIST = filelist.f
OBJDIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fails unless the run passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "** PASS **"

clean:
	rm -rf $(OBJDIR)

/* tb_stream_copy.sv */
`timescale 1ns/1ps
`include "stream_copy_consts.svh"

// Testbench for the stream copy engine
// Random register, window and transfer tests checked against a memory model
module tb_stream_copy import ctrl_pkg::*; ();

  // 4 COPY + 2 op transfers of up to 32, one of 32, then 1 + 64 + 1
  localparam int MAX_WORDS      = 290;
  localparam int TIMEOUT_CYCLES = 200 * MAX_WORDS + 5000;

  logic               clk;
  logic               rst_n;
  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [`APB_AW-1:0] paddr;
  logic [`DATA_W-1:0] pwdata;
  logic [`DATA_W-1:0] prdata;
  logic               pready;
  logic               pslverr;

  logic [`DATA_W-1:0] ref_mem [`MEM_WORDS];  // Expected memory contents
  logic [31:0]        seed = 32'h2787c71c;
  int                 checks = 0;
  int                 errors = 0;

  stream_copy_top DUT (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int rand_below(input int n);
    return int'((lcg_next() >> 8) % n);  // Upper bits are the better ones
  endfunction

  // Expected result of one word under each opcode
  function automatic logic [31:0] apply_op(input copy_op_e op, input logic [31:0] d,
                                           input logic [31:0] key);
    logic [31:0] r;
    logic [8:0]  sum;
    r = d;
    if (op == OP_INVERT)
      r = ~d;
    else if (op == OP_ADD_KEY) begin
      for (int b = 0; b < 4; b++) begin
        sum          = {1'b0, d[8*b +: 8]} + {1'b0, key[8*b +: 8]};
        r[8*b +: 8]  = sum[7:0];
      end
    end
    return r;
  endfunction

  function automatic logic [`APB_AW-1:0] win_addr(input logic [`MEM_AW-1:0] a);
    return `WIN_BASE + {a, 2'b00};
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("FAIL t=%0t %s expected %08h got %08h", $time, name, exp, act);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  // One APB transfer driven 1 ns after the edge with pready sampled mid-cycle
  task automatic apb_access(input logic wr, input logic [`APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    while (!pready)
      @(negedge clk);  // Window accesses wait for the arbiter
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic reg_write(input logic [`APB_AW-1:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    logic        err;
    apb_access(1'b1, addr, data, unused, err);
    check_val("pslverr_o", 32'h0, 32'(err));
  endtask

  task automatic reg_read(input logic [`APB_AW-1:0] addr, output logic [31:0] data);
    logic err;
    apb_access(1'b0, addr, '0, data, err);
    check_val("pslverr_o", 32'h0, 32'(err));
  endtask

  task automatic reg_roundtrip(input logic [`APB_AW-1:0] addr, input string name,
                               input logic [31:0] mask);
    logic [31:0] wr;
    logic [31:0] rd;
    wr = lcg_next();
    reg_write(addr, wr);
    reg_read(addr, rd);
    check_val(name, wr & mask, rd);
  endtask

  task automatic verify_mem();
    logic [31:0] d;
    for (int a = 0; a < `MEM_WORDS; a++) begin
      reg_read(win_addr(a[`MEM_AW-1:0]), d);
      check_val($sformatf("mem[%0d]", a), ref_mem[a], d);
    end
  endtask

  // Source and destination ranges that do not overlap modulo the depth
  task automatic pick_ranges(input int len, output logic [`MEM_AW-1:0] src,
                             output logic [`MEM_AW-1:0] dst);
    int off;
    src = rand_below(`MEM_WORDS);
    off = rand_below(`MEM_WORDS - 2 * len + 1);
    dst = src + len + off;
  endtask

  task automatic start_transfer(input logic [`MEM_AW-1:0] src, input logic [`MEM_AW-1:0] dst,
                                input int len, input copy_op_e op, input logic [31:0] key);
    logic [31:0]        snap [`MEM_WORDS];
    logic [`MEM_AW-1:0] s;
    logic [`MEM_AW-1:0] t;
    reg_write(`REG_SRC, 32'(src));
    reg_write(`REG_DST, 32'(dst));
    reg_write(`REG_LEN, 32'(len));
    reg_write(`REG_KEY, key);
    snap = ref_mem;  // Sources are read before their own address is written
    s    = src;
    t    = dst;
    for (int i = 0; i < len; i++) begin
      ref_mem[t] = apply_op(op, snap[s], key);
      s = s + 1'b1;
      t = t + 1'b1;
    end
    reg_write(`REG_CTRL, {29'd0, op, 1'b1});
  endtask

  task automatic wait_done();
    logic [31:0] st;
    st = '0;
    while (!st[1])
      reg_read(`REG_STATUS, st);
    check_val("STATUS", 32'h2, st);  // Done set, busy clear
  endtask

  initial begin
    logic [31:0]        d;
    logic               err;
    logic [`MEM_AW-1:0] src;
    logic [`MEM_AW-1:0] dst;
    int                 len;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    rst_n   = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Reset state, register readback and an unmapped address
    @(negedge clk);
    check_val("pready_o", 32'h0, 32'(pready));
    check_val("pslverr_o", 32'h0, 32'(pslverr));
    reg_read(`REG_STATUS, d);
    check_val("STATUS", 32'h0, d);
    reg_roundtrip(`REG_SRC, "SRC", 32'h3f);
    reg_roundtrip(`REG_DST, "DST", 32'h3f);
    reg_roundtrip(`REG_LEN, "LEN", 32'h7f);
    reg_roundtrip(`REG_KEY, "KEY", 32'hffff_ffff);
    apb_access(1'b0, 12'h020, '0, d, err);
    check_true(err, "read of unmapped address 0x020 completed without pslverr");
    apb_access(1'b1, 12'h200, lcg_next(), d, err);
    check_true(err, "write past the memory window completed without pslverr");

    // Fill the whole memory through the window
    for (int a = 0; a < `MEM_WORDS; a++) begin
      d          = lcg_next();
      ref_mem[a] = d;
      reg_write(win_addr(a[`MEM_AW-1:0]), d);
    end
    verify_mem();

    repeat (4) begin
      len = 1 + rand_below(32);
      pick_ranges(len, src, dst);
      start_transfer(src, dst, len, OP_COPY, lcg_next());
      wait_done();
      verify_mem();
    end

    len = 1 + rand_below(32);
    pick_ranges(len, src, dst);
    start_transfer(src, dst, len, OP_INVERT, lcg_next());
    wait_done();
    verify_mem();
    len = 1 + rand_below(32);
    pick_ranges(len, src, dst);
    start_transfer(src, dst, len, OP_ADD_KEY, lcg_next());
    wait_done();
    verify_mem();

    // Window reads and a second start while a long transfer runs
    pick_ranges(32, src, dst);
    start_transfer(src, dst, 32, OP_ADD_KEY, lcg_next());
    reg_write(`REG_CTRL, {29'd0, OP_INVERT, 1'b1});
    reg_read(`REG_STATUS, d);
    check_val("STATUS", 32'h1, d);
    for (int i = 0; i < 8; i++) begin
      reg_read(win_addr(src + i[`MEM_AW-1:0]), d);
      check_val($sformatf("mem[%0d]", src + i[`MEM_AW-1:0]), ref_mem[src + i[`MEM_AW-1:0]], d);
    end
    wait_done();
    verify_mem();

    // Back to back with LEN 1, LEN 64 in place, LEN 1
    pick_ranges(1, src, dst);
    start_transfer(src, dst, 1, OP_COPY, lcg_next());
    wait_done();
    src = rand_below(`MEM_WORDS);
    start_transfer(src, src, 64, OP_INVERT, lcg_next());
    reg_read(`REG_STATUS, d);
    check_val("STATUS", 32'h1, d);  // Done cleared by the new start
    wait_done();
    verify_mem();
    pick_ranges(1, src, dst);
    start_transfer(src, dst, 1, OP_ADD_KEY, lcg_next());
    wait_done();
    verify_mem();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
    $display("Checks run: %0d, errors: %0d", checks, errors + 1);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* stream_copy_top.sv */
`timescale 1ns/1ps
`include "stream_copy_consts.svh"

// Stream copy engine top level
// APB registers, reader, FIFO and writer sharing one memory through an arbiter
module stream_copy_top import ctrl_pkg::*, stream_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [`APB_AW-1:0] paddr_i,
  input  logic [`DATA_W-1:0] pwdata_i,
  output logic [`DATA_W-1:0] prdata_o,
  output logic               pready_o,
  output logic               pslverr_o
);

  logic               start;
  logic               done;
  copy_op_e           op;
  logic [`MEM_AW-1:0] src;
  logic [`MEM_AW-1:0] dst;
  logic [`MEM_AW:0]   len;
  logic [`DATA_W-1:0] key;
  flags_fifo_t        flags;

  logic               push_valid;
  logic               push_ready;
  logic [`DATA_W-1:0] push_data;
  logic [`STRB_W-1:0] push_strb;
  logic               pop_valid;
  logic               pop_ready;
  logic [`DATA_W-1:0] pop_data;
  logic [`STRB_W-1:0] pop_strb;

  // Requester sides, one set per peer
  logic               rd_req;
  logic               rd_we;
  logic               rd_gnt;
  logic               rd_rvalid;
  logic [`MEM_AW-1:0] rd_addr;
  logic [`DATA_W-1:0] rd_wdata;
  logic [`STRB_W-1:0] rd_strb;
  logic               wr_req;
  logic               wr_we;
  logic               wr_gnt;
  logic               wr_rvalid;
  logic [`MEM_AW-1:0] wr_addr;
  logic [`DATA_W-1:0] wr_wdata;
  logic [`STRB_W-1:0] wr_strb;
  logic               win_req;
  logic               win_we;
  logic               win_gnt;
  logic               win_rvalid;
  logic [`MEM_AW-1:0] win_addr;
  logic [`DATA_W-1:0] win_wdata;
  logic [`DATA_W-1:0] arb_rdata;

  logic               mem_req;
  logic               mem_we;
  logic [`MEM_AW-1:0] mem_addr;
  logic [`DATA_W-1:0] mem_wdata;
  logic [`STRB_W-1:0] mem_strb;
  logic [`DATA_W-1:0] mem_rdata;

  apb_ctrl_regs u_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .start_o      (start),
    .op_o         (op),
    .src_o        (src),
    .dst_o        (dst),
    .len_o        (len),
    .key_o        (key),
    .done_i       (done),
    .win_req_o    (win_req),
    .win_we_o     (win_we),
    .win_addr_o   (win_addr),
    .win_wdata_o  (win_wdata),
    .win_gnt_i    (win_gnt),
    .win_rvalid_i (win_rvalid),
    .win_rdata_i  (arb_rdata)
  );

  stream_reader u_reader (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start),
    .src_i        (src),
    .len_i        (len),
    .mem_req_o    (rd_req),
    .mem_we_o     (rd_we),
    .mem_addr_o   (rd_addr),
    .mem_wdata_o  (rd_wdata),
    .mem_strb_o   (rd_strb),
    .mem_gnt_i    (rd_gnt),
    .mem_rvalid_i (rd_rvalid),
    .mem_rdata_i  (arb_rdata),
    .push_valid_o (push_valid),
    .push_data_o  (push_data),
    .push_strb_o  (push_strb),
    .push_ready_i (push_ready)
  );

  stream_fifo #(
    .FIFO_DEPTH (4)
  ) u_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (start),  // Drop leftovers of the previous transfer
    .push_valid_i (push_valid),
    .push_data_i  (push_data),
    .push_strb_i  (push_strb),
    .push_ready_o (push_ready),
    .pop_valid_o  (pop_valid),
    .pop_data_o   (pop_data),
    .pop_strb_o   (pop_strb),
    .pop_ready_i  (pop_ready),
    .flags_o      (flags)
  );

  stream_writer u_writer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start),
    .dst_i        (dst),
    .len_i        (len),
    .op_i         (op),
    .key_i        (key),
    .flags_i      (flags),
    .pop_valid_i  (pop_valid),
    .pop_data_i   (pop_data),
    .pop_strb_i   (pop_strb),
    .pop_ready_o  (pop_ready),
    .mem_req_o    (wr_req),
    .mem_we_o     (wr_we),
    .mem_addr_o   (wr_addr),
    .mem_wdata_o  (wr_wdata),
    .mem_strb_o   (wr_strb),
    .mem_gnt_i    (wr_gnt),
    .mem_rvalid_i (wr_rvalid),
    .done_o       (done)
  );

  mem_arbiter u_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       ({win_req, wr_req, rd_req}),
    .we_i        ({win_we, wr_we, rd_we}),
    .addr_i      ({win_addr, wr_addr, rd_addr}),
    .wdata_i     ({win_wdata, wr_wdata, rd_wdata}),
    .strb_i      ({{`STRB_W{1'b1}}, wr_strb, rd_strb}),  // Window uses whole words
    .gnt_o       ({win_gnt, wr_gnt, rd_gnt}),
    .rvalid_o    ({win_rvalid, wr_rvalid, rd_rvalid}),
    .rdata_o     (arb_rdata),
    .mem_req_o   (mem_req),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_strb_o  (mem_strb),
    .mem_rdata_i (mem_rdata)
  );

  word_mem u_mem (
    .clk_i   (clk_i),
    .req_i   (mem_req),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .strb_i  (mem_strb),
    .rdata_o (mem_rdata)
  );

endmodule

/* stream_writer.sv */
`timescale 1ns/1ps
`include "stream_copy_consts.svh"

// Pops the stream FIFO, applies the copy opcode and writes the destination
// Pulses done once the last word has been granted
module stream_writer import ctrl_pkg::*, stream_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               start_i,
  input  logic [`MEM_AW-1:0] dst_i,
  input  logic [`MEM_AW:0]   len_i,
  input  copy_op_e           op_i,
  input  logic [`DATA_W-1:0] key_i,
  input  flags_fifo_t        flags_i,
  input  logic               pop_valid_i,
  input  logic [`DATA_W-1:0] pop_data_i,
  input  logic [`STRB_W-1:0] pop_strb_i,
  output logic               pop_ready_o,
  output logic               mem_req_o,
  output logic               mem_we_o,
  output logic [`MEM_AW-1:0] mem_addr_o,
  output logic [`DATA_W-1:0] mem_wdata_o,
  output logic [`STRB_W-1:0] mem_strb_o,
  input  logic               mem_gnt_i,
  input  logic               mem_rvalid_i,
  output logic               done_o
);

  logic [`MEM_AW-1:0] addr_q;
  logic [`MEM_AW:0]   left_q;
  logic               req_q;

  always_comb begin
    case (op_i)
      OP_INVERT: mem_wdata_o = ~pop_data_i;
      OP_ADD_KEY: begin
        for (int b = 0; b < `STRB_W; b++)
          mem_wdata_o[8*b +: 8] = pop_data_i[8*b +: 8] + key_i[8*b +: 8];  // Carry dropped
      end
      default: mem_wdata_o = pop_data_i;
    endcase
  end

  assign mem_req_o   = req_q;
  assign mem_we_o    = 1'b1;
  assign mem_addr_o  = addr_q;
  assign mem_strb_o  = pop_strb_i;
  assign pop_ready_o = req_q & mem_gnt_i;  // Head leaves once written

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
      left_q <= '0;
      req_q  <= 1'b0;
      done_o <= 1'b0;
    end else if (start_i) begin
      addr_q <= dst_i;
      left_q <= len_i;
      req_q  <= 1'b0;
      done_o <= 1'b0;
    end else begin
      done_o <= req_q && mem_gnt_i && (left_q == 1);
      if (req_q && mem_gnt_i) begin
        req_q  <= 1'b0;
        addr_q <= addr_q + 1'b1;
        left_q <= left_q - 1'b1;
      end else if (pop_valid_i && (left_q != '0)) begin
        req_q <= 1'b1;
      end
    end
  end

  // The word being written is still at the FIFO head
  a_head_present: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_q |-> !flags_i.empty);

  // Writes only, so no read data is ever routed here
  a_no_read_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !mem_rvalid_i);

endmodule

/* stream_reader.sv */
`timescale 1ns/1ps
`include "stream_copy_consts.svh"

// Reads LEN source words one at a time and pushes them into the stream FIFO
module stream_reader (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               start_i,
  input  logic [`MEM_AW-1:0] src_i,
  input  logic [`MEM_AW:0]   len_i,
  output logic               mem_req_o,
  output logic               mem_we_o,
  output logic [`MEM_AW-1:0] mem_addr_o,
  output logic [`DATA_W-1:0] mem_wdata_o,
  output logic [`STRB_W-1:0] mem_strb_o,
  input  logic               mem_gnt_i,
  input  logic               mem_rvalid_i,
  input  logic [`DATA_W-1:0] mem_rdata_i,
  output logic               push_valid_o,
  output logic [`DATA_W-1:0] push_data_o,
  output logic [`STRB_W-1:0] push_strb_o,
  input  logic               push_ready_i
);

  logic [`MEM_AW-1:0] addr_q;
  logic [`MEM_AW:0]   left_q;      // Words still to request
  logic               inflight_q;
  logic               hold_q;      // Returned word waiting for the FIFO
  logic [`DATA_W-1:0] data_q;

  assign mem_req_o    = (left_q != '0) && !inflight_q && !hold_q;
  assign mem_we_o     = 1'b0;
  assign mem_addr_o   = addr_q;
  assign mem_wdata_o  = '0;
  assign mem_strb_o   = '1;
  assign push_valid_o = hold_q;
  assign push_data_o  = data_q;
  assign push_strb_o  = '1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q     <= '0;
      left_q     <= '0;
      inflight_q <= 1'b0;
      hold_q     <= 1'b0;
    end else if (start_i) begin
      addr_q     <= src_i;
      left_q     <= len_i;
      inflight_q <= 1'b0;
      hold_q     <= 1'b0;
    end else begin
      if (mem_req_o && mem_gnt_i) begin
        addr_q     <= addr_q + 1'b1;  // Wraps with the memory depth
        left_q     <= left_q - 1'b1;
        inflight_q <= 1'b1;
      end
      if (mem_rvalid_i) begin
        inflight_q <= 1'b0;
        hold_q     <= 1'b1;
      end
      if (push_valid_o && push_ready_i)
        hold_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_rvalid_i)
      data_q <= mem_rdata_i;
  end

endmodule

/* apb_ctrl_regs.sv */
`timescale 1ns/1ps
`include "stream_copy_consts.svh"

// APB slave with the copy configuration, busy/done status
// and a window that reaches the word memory through the arbiter
module apb_ctrl_regs import ctrl_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [`APB_AW-1:0] paddr_i,
  input  logic [`DATA_W-1:0] pwdata_i,
  output logic [`DATA_W-1:0] prdata_o,
  output logic               pready_o,
  output logic               pslverr_o,
  output logic               start_o,
  output copy_op_e           op_o,
  output logic [`MEM_AW-1:0] src_o,
  output logic [`MEM_AW-1:0] dst_o,
  output logic [`MEM_AW:0]   len_o,
  output logic [`DATA_W-1:0] key_o,
  input  logic               done_i,
  output logic               win_req_o,
  output logic               win_we_o,
  output logic [`MEM_AW-1:0] win_addr_o,
  output logic [`DATA_W-1:0] win_wdata_o,
  input  logic               win_gnt_i,
  input  logic               win_rvalid_i,
  input  logic [`DATA_W-1:0] win_rdata_i
);

  ctrl_state_e        state_q;
  logic               done_q;
  logic               rd_wait_q;
  logic               access;
  logic               win_hit;
  logic               reg_hit;
  logic [`APB_AW-1:0] win_off;
  logic [`DATA_W-1:0] reg_rdata;

  assign access      = psel_i & penable_i;
  assign win_hit     = (paddr_i >= `WIN_BASE) && (paddr_i < `WIN_BASE + 4 * `MEM_WORDS);
  assign win_off     = paddr_i - `WIN_BASE;
  assign win_addr_o  = win_off[`MEM_AW+1:2];
  assign win_we_o    = pwrite_i;
  assign win_wdata_o = pwdata_i;
  assign win_req_o   = access & win_hit & ~rd_wait_q;  // Off while read data is due

  always_comb begin
    reg_hit   = 1'b1;
    reg_rdata = '0;
    case (paddr_i)
      `REG_CTRL:   reg_rdata = '0;  // Write-only
      `REG_STATUS: reg_rdata = `DATA_W'({done_q, state_q == BUSY});
      `REG_SRC:    reg_rdata = `DATA_W'(src_o);
      `REG_DST:    reg_rdata = `DATA_W'(dst_o);
      `REG_LEN:    reg_rdata = `DATA_W'(len_o);
      `REG_KEY:    reg_rdata = key_o;
      default:     reg_hit   = 1'b0;
    endcase
  end

  // Registers answer at once, the window waits for grant or read data
  assign pready_o  = access & (~win_hit | (pwrite_i ? win_gnt_i : (rd_wait_q & win_rvalid_i)));
  assign pslverr_o = access & ~win_hit & ~reg_hit;
  assign prdata_o  = win_hit ? win_rdata_i : reg_rdata;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      done_q    <= 1'b0;
      start_o   <= 1'b0;
      rd_wait_q <= 1'b0;
      op_o      <= OP_COPY;
      src_o     <= '0;
      dst_o     <= '0;
      len_o     <= '0;
      key_o     <= '0;
    end else begin
      start_o <= 1'b0;
      if (win_req_o && win_gnt_i && !pwrite_i)
        rd_wait_q <= 1'b1;
      else if (win_rvalid_i)
        rd_wait_q <= 1'b0;
      if (done_i) begin
        state_q <= IDLE;
        done_q  <= 1'b1;  // Sticky until next start
      end
      if (access && pwrite_i && !win_hit) begin
        case (paddr_i)
          `REG_CTRL: begin
            if (pwdata_i[0] && (state_q == IDLE)) begin
              start_o <= 1'b1;
              op_o    <= copy_op_e'(pwdata_i[2:1]);
              state_q <= BUSY;
              done_q  <= 1'b0;
            end
          end
          `REG_SRC: src_o <= pwdata_i[`MEM_AW-1:0];
          `REG_DST: dst_o <= pwdata_i[`MEM_AW-1:0];
          `REG_LEN: len_o <= pwdata_i[`MEM_AW:0];
          `REG_KEY: key_o <= pwdata_i;
          default: ;
        endcase
      end
    end
  end

  // The APB master holds the access until the window is granted
  a_win_in_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (win_req_o && !win_gnt_i) |=> (psel_i && penable_i && win_req_o));

endmodule

/* mem_arbiter.sv */
`timescale 1ns/1ps
`include "stream_copy_consts.svh"

// Round-robin arbiter for reader, writer and APB window in front of the memory
// Read data is steered back to the requester that issued the read
module mem_arbiter import ctrl_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [2:0]              req_i,
  input  logic [2:0]              we_i,
  input  logic [2:0][`MEM_AW-1:0] addr_i,
  input  logic [2:0][`DATA_W-1:0] wdata_i,
  input  logic [2:0][`STRB_W-1:0] strb_i,
  output logic [2:0]              gnt_o,
  output logic [2:0]              rvalid_o,
  output logic [`DATA_W-1:0]      rdata_o,
  output logic                    mem_req_o,
  output logic                    mem_we_o,
  output logic [`MEM_AW-1:0]      mem_addr_o,
  output logic [`DATA_W-1:0]      mem_wdata_o,
  output logic [`STRB_W-1:0]      mem_strb_o,
  input  logic [`DATA_W-1:0]      mem_rdata_i
);

  req_id_e last_q;
  req_id_e owner_q;
  req_id_e win;
  logic    found;
  logic    rd_pend_q;

  // Search starts right after the last winner
  always_comb begin
    int unsigned idx;
    win   = last_q;
    found = 1'b0;
    for (int k = 1; k <= 3; k++) begin
      idx = (int'(last_q) + k) % 3;
      if (!found && req_i[idx]) begin
        win   = req_id_e'(idx);
        found = 1'b1;
      end
    end
  end

  assign gnt_o       = found ? (3'b001 << win) : 3'b000;
  assign mem_req_o   = found;
  assign mem_we_o    = we_i[win];
  assign mem_addr_o  = addr_i[win];
  assign mem_wdata_o = wdata_i[win];
  assign mem_strb_o  = strb_i[win];
  assign rvalid_o    = rd_pend_q ? (3'b001 << owner_q) : 3'b000;
  assign rdata_o     = mem_rdata_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q    <= RQ_APB;  // Reader goes first
      owner_q   <= RQ_READER;
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= found && !we_i[win];
      if (found) begin
        last_q  <= win;
        owner_q <= win;
      end
    end
  end

  // A requester that loses arbitration keeps asking
  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ($past(req_i & ~gnt_o) & ~req_i) == 3'b000);

endmodule

/* word_mem.sv */
`timescale 1ns/1ps
`include "stream_copy_consts.svh"

// Single-port word memory with byte strobes and one-cycle read latency
module word_mem (
  input  logic               clk_i,
  input  logic               req_i,
  input  logic               we_i,
  input  logic [`MEM_AW-1:0] addr_i,
  input  logic [`DATA_W-1:0] wdata_i,
  input  logic [`STRB_W-1:0] strb_i,
  output logic [`DATA_W-1:0] rdata_o
);

  logic [`DATA_W-1:0] mem_q [`MEM_WORDS];

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < `STRB_W; b++) begin
        if (strb_i[b])
          mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end else if (req_i) begin
      rdata_o <= mem_q[addr_i];  // Valid the cycle after the grant
    end
  end

endmodule

/* stream_fifo.sv */
`timescale 1ns/1ps
`include "stream_copy_consts.svh"

// Stream FIFO holding a data word and byte strobe per entry
// Empty/middle/full FSM steers circular push and pop pointers
module stream_fifo import stream_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clear_i,
  input  logic               push_valid_i,
  input  logic [`DATA_W-1:0] push_data_i,
  input  logic [`STRB_W-1:0] push_strb_i,
  output logic               push_ready_o,
  output logic               pop_valid_o,
  output logic [`DATA_W-1:0] pop_data_o,
  output logic [`STRB_W-1:0] pop_strb_o,
  input  logic               pop_ready_i,
  output flags_fifo_t        flags_o
);

  localparam int unsigned PTR_W = (FIFO_DEPTH == 1) ? 1 : $clog2(FIFO_DEPTH);

  fifo_state_e                 state_q;
  fifo_state_e                 state_d;
  logic [PTR_W-1:0]            push_ptr_q;
  logic [PTR_W-1:0]            pop_ptr_q;
  logic [PTR_W-1:0]            push_ptr_nxt;
  logic [PTR_W-1:0]            pop_ptr_nxt;
  logic [`DATA_W+`STRB_W-1:0]  fifo_q [FIFO_DEPTH];
  logic                        push;
  logic                        pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push_ready_o  = (state_q != FULL);
  assign pop_valid_o   = (state_q != EMPTY);
  assign push          = push_valid_i & push_ready_o;
  assign pop           = pop_valid_o & pop_ready_i;
  assign push_ptr_nxt  = ptr_inc(push_ptr_q);
  assign pop_ptr_nxt   = ptr_inc(pop_ptr_q);
  assign flags_o.empty = (state_q == EMPTY);

  always_comb begin
    state_d = state_q;
    case (state_q)
      EMPTY: begin
        if (push)
          state_d = (push_ptr_nxt == pop_ptr_q) ? FULL : MIDDLE;
      end
      MIDDLE: begin
        if (push && !pop && (push_ptr_nxt == pop_ptr_q))
          state_d = FULL;
        else if (pop && !push && (pop_ptr_nxt == push_ptr_q))
          state_d = EMPTY;  // Last entry leaves
      end
      FULL: begin
        if (pop)
          state_d = (pop_ptr_nxt == push_ptr_q) ? EMPTY : MIDDLE;
      end
      default: state_d = EMPTY;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= EMPTY;
      push_ptr_q <= '0;
      pop_ptr_q  <= '0;
    end else if (clear_i) begin
      state_q    <= EMPTY;
      push_ptr_q <= '0;
      pop_ptr_q  <= '0;
    end else begin
      state_q <= state_d;
      if (push)
        push_ptr_q <= push_ptr_nxt;
      if (pop)
        pop_ptr_q <= pop_ptr_nxt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push)
      fifo_q[push_ptr_q] <= {push_data_i, push_strb_i};
  end

  // Head entry, zero while nothing is stored
  assign pop_data_o = pop_valid_o ? fifo_q[pop_ptr_q][`DATA_W+`STRB_W-1:`STRB_W] : '0;
  assign pop_strb_o = pop_valid_o ? fifo_q[pop_ptr_q][`STRB_W-1:0] : '0;

  // A producer stalled by a full FIFO keeps its word
  a_push_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (push_valid_i && !push_ready_o && !clear_i) |=> (push_valid_i && $stable(push_data_i)));

  a_pop_valid_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(pop_valid_o));

endmodule

/* ctrl_pkg.sv */
// Control side types
// Copy opcodes, controller states and memory requester ids
package ctrl_pkg;

  typedef enum logic [1:0] {
    OP_COPY    = 2'd0,
    OP_INVERT  = 2'd1,  // Bitwise not
    OP_ADD_KEY = 2'd2   // Bytewise add of KEY, mod 256
  } copy_op_e;

  typedef enum logic {
    IDLE = 1'b0,
    BUSY = 1'b1
  } ctrl_state_e;

  typedef enum logic [1:0] {
    RQ_READER = 2'd0,
    RQ_WRITER = 2'd1,
    RQ_APB    = 2'd2
  } req_id_e;

endpackage

/* stream_pkg.sv */
// Stream side types
// FIFO state encoding and the flags the FIFO reports
package stream_pkg;

  typedef enum logic [1:0] {
    EMPTY  = 2'd0,
    MIDDLE = 2'd1,
    FULL   = 2'd2
  } fifo_state_e;

  typedef struct packed {
    logic empty;
  } flags_fifo_t;

endpackage

/* stream_copy_consts.svh */
// Stream copy engine constants
// Word geometry, memory size and the APB register map
`ifndef STREAM_COPY_CONSTS_SVH
`define STREAM_COPY_CONSTS_SVH

`define DATA_W    32
`define STRB_W    4
`define MEM_WORDS 64
`define MEM_AW    6
`define APB_AW    12

`define REG_CTRL   12'h000  // Start and opcode
`define REG_STATUS 12'h004
`define REG_SRC    12'h008
`define REG_DST    12'h00C
`define REG_LEN    12'h010
`define REG_KEY    12'h014
`define WIN_BASE   12'h100  // Memory window, one word per 4 bytes

`endif
